// File: run_sim.sh
#!/bin/sh
# Build the super block testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_sblk_unit -f sblk_unit.f -Mdir obj_dir -o sim_sblk
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_sblk > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -q "^All tests passed$" sim.log; then
   exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: sblk_unit.f
source/sblk_cfg_pkg.sv
source/sblk_cmd_pkg.sv
source/skew_line.sv
source/sblk_tile.sv
source/psum_buf.sv
source/sblk_ctrl.sv
source/sblk_unit.sv
tb/sblk_unit_assert.sv
tb/tb_sblk_unit.sv

// File: source/psum_buf.sv
// Partial-sum memory with accumulate read port, host read port and write port
`timescale 1ns/100ps

module psum_buf (
   input  logic                     clk_h,
   input  logic                     rst_n,
   input  logic                     rd_en,
   input  sblk_cfg_pkg::psum_addr_t rd_addr,
   output sblk_cfg_pkg::psum_t      acc_data,
   input  logic                     host_rd_en,
   input  sblk_cfg_pkg::psum_addr_t host_rd_addr,
   output sblk_cfg_pkg::psum_t      host_rd_data,
   output logic                     host_rd_valid,
   input  sblk_cmd_pkg::psum_wb_t   wb,
   input  sblk_cfg_pkg::psum_t      wr_data
);

   import sblk_cfg_pkg::*;

   psum_t mem [PSUM_DEPTH];

   // First read stage of both ports
   psum_t acc_rd_q;
   psum_t host_rd_q;
   logic  acc_en_q;
   logic  host_en_q;

   // Write from the end of the chain, reads see the old entry on a collision
   always_ff @(posedge clk_h) begin
      if (wb.valid) begin
         mem[wb.addr] <= wr_data;
      end
      if (rd_en) begin
         acc_rd_q <= mem[rd_addr];
      end
      if (host_rd_en) begin
         host_rd_q <= mem[host_rd_addr];
      end
   end

   // Second stage, output registers
   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         acc_en_q      <= 1'b0;
         host_en_q     <= 1'b0;
         acc_data      <= '0;
         host_rd_data  <= '0;
         host_rd_valid <= 1'b0;
      end else begin
         acc_en_q      <= rd_en;
         host_en_q     <= host_rd_en;
         // Zero seeds the chain head for a plain (non-accumulating) step
         acc_data      <= acc_en_q ? acc_rd_q : '0;
         host_rd_data  <= host_rd_q;
         host_rd_valid <= host_en_q;
      end
   end

endmodule

// File: source/sblk_cfg_pkg.sv
// Data widths, buffer depths, tile count limits and datapath types
package sblk_cfg_pkg;

   // Datapath word widths
   localparam int ACT_W  = 16;
   localparam int W_W    = 16;
   localparam int PSUM_W = 32;

   // Per-tile buffer depths and partial-sum buffer depth
   localparam int ACT_DEPTH  = 32;
   localparam int W_DEPTH    = 32;
   localparam int PSUM_DEPTH = 64;

   // Tile row size, default and upper bound
   localparam int N_TILE_DEF = 4;
   localparam int N_TILE_MAX = 8;

   // Signed operands, products are formed at full 32 bits
   typedef logic signed [ACT_W-1:0]  act_t;
   typedef logic signed [W_W-1:0]    w_t;
   typedef logic signed [PSUM_W-1:0] psum_t;

   // Buffer addresses, all wrap at their depth
   typedef logic [$clog2(ACT_DEPTH)-1:0]  act_addr_t;
   typedef logic [$clog2(W_DEPTH)-1:0]    w_addr_t;
   typedef logic [$clog2(PSUM_DEPTH)-1:0] psum_addr_t;

   // Step count 1..PSUM_DEPTH needs one extra bit
   typedef logic [$clog2(PSUM_DEPTH):0]   len_t;
   typedef logic [$clog2(N_TILE_MAX)-1:0] tile_idx_t;

endpackage

// File: source/sblk_cmd_pkg.sv
// Load, compute command, step address and write-back record structs
package sblk_cmd_pkg;

   import sblk_cfg_pkg::*;

   // Activation write into one tile's buffer
   typedef struct packed {
      logic      valid;
      tile_idx_t tile;
      act_addr_t addr;
      act_t      data;
   } act_load_t;

   // Weight write, same layout as the activation load
   typedef struct packed {
      logic      valid;
      tile_idx_t tile;
      w_addr_t   addr;
      w_t        data;
   } w_load_t;

   // Compute command
   typedef struct packed {
      act_addr_t  act_base;
      w_addr_t    w_base;
      psum_addr_t psum_base;
      len_t       len;
      logic       acc;
   } sblk_cmd_t;

   // One step of buffer addresses, skewed down the tile row
   typedef struct packed {
      logic      valid;
      act_addr_t act_addr;
      w_addr_t   w_addr;
   } step_addr_t;

   // Partial-sum write, delayed to meet the end of the chain
   typedef struct packed {
      logic       valid;
      logic       last;
      psum_addr_t addr;
   } psum_wb_t;

endpackage

// File: source/sblk_ctrl.sv
// Command sequencer with command latch, step address counters, accumulate read and done
`timescale 1ns/100ps

module sblk_ctrl #(
   parameter int N_TILE = sblk_cfg_pkg::N_TILE_DEF
) (
   input  logic                     clk_h,
   input  logic                     rst_n,
   input  sblk_cmd_pkg::sblk_cmd_t  cmd,
   input  logic                     cmd_valid,
   output logic                     cmd_ready,
   output sblk_cmd_pkg::step_addr_t step,
   output sblk_cmd_pkg::psum_wb_t   wb,
   output logic                     psum_rd_en,
   output sblk_cfg_pkg::psum_addr_t psum_rd_addr,
   input  sblk_cmd_pkg::psum_wb_t   wb_tap,
   output logic                     done
);

   import sblk_cfg_pkg::*;
   import sblk_cmd_pkg::*;

   // Busy spans acceptance to done, issue spans the L step cycles only
   logic       busy_q;
   logic       issue_q;
   logic       acc_q;
   logic       done_q;
   len_t       rem_q;
   act_addr_t  act_addr_q;
   w_addr_t    w_addr_q;
   psum_addr_t psum_addr_q;

   logic       cmd_accept;
   logic       last_step;

   // Tile index field and skew lines are sized for this range
   generate
      if (N_TILE < 1 || N_TILE > N_TILE_MAX) begin : g_bad_n_tile
         $error("sblk_ctrl: N_TILE out of range 1..%0d", N_TILE_MAX);
      end
   endgenerate

   assign cmd_accept = cmd_valid & cmd_ready;
   // A zero length is treated as a single step
   assign last_step  = issue_q && (rem_q <= len_t'(1));

   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         busy_q      <= 1'b0;
         issue_q     <= 1'b0;
         acc_q       <= 1'b0;
         done_q      <= 1'b0;
         rem_q       <= '0;
         act_addr_q  <= '0;
         w_addr_q    <= '0;
         psum_addr_q <= '0;
      end else begin
         done_q <= 1'b0;
         if (cmd_accept) begin
            // First step goes out in the next cycle with the base addresses
            busy_q      <= 1'b1;
            issue_q     <= 1'b1;
            acc_q       <= cmd.acc;
            rem_q       <= cmd.len;
            act_addr_q  <= cmd.act_base;
            w_addr_q    <= cmd.w_base;
            psum_addr_q <= cmd.psum_base;
         end else if (issue_q) begin
            // Counters wrap at the buffer depth by width
            act_addr_q  <= act_addr_q + act_addr_t'(1);
            w_addr_q    <= w_addr_q + w_addr_t'(1);
            psum_addr_q <= psum_addr_q + psum_addr_t'(1);
            rem_q       <= rem_q - len_t'(1);
            if (last_step) begin
               issue_q <= 1'b0;
            end
         end
         // Done follows the last buffer write by one cycle
         if (busy_q && wb_tap.valid && wb_tap.last) begin
            busy_q <= 1'b0;
            done_q <= 1'b1;
         end
      end
   end

   assign cmd_ready = ~busy_q;
   assign done      = done_q;

   // Step and write-back records for the current issue cycle
   always_comb begin
      step          = '0;
      step.valid    = issue_q;
      step.act_addr = act_addr_q;
      step.w_addr   = w_addr_q;

      wb            = '0;
      wb.valid      = issue_q;
      wb.last       = last_step;
      wb.addr       = psum_addr_q;
   end

   // Stored partial sum is only fetched for accumulating commands
   assign psum_rd_en   = issue_q & acc_q;
   assign psum_rd_addr = psum_addr_q;

endmodule

// File: source/sblk_tile.sv
// Multiply-accumulate tile with activation and weight buffers and a cascaded sum register
`timescale 1ns/100ps

module sblk_tile #(
   parameter int TILE_IDX = 0
) (
   input  logic                     clk_h,
   input  logic                     rst_n,
   input  sblk_cmd_pkg::act_load_t  act_load,
   input  sblk_cmd_pkg::w_load_t    w_load,
   input  sblk_cmd_pkg::step_addr_t step,
   input  sblk_cfg_pkg::psum_t      sum_in,
   output sblk_cfg_pkg::psum_t      sum_out
);

   import sblk_cfg_pkg::*;

   // Local operand buffers
   act_t  act_mem [ACT_DEPTH];
   w_t    w_mem   [W_DEPTH];

   // Read stage
   act_t  act_q;
   w_t    w_q;
   logic  rd_vld_q;

   logic  act_hit;
   logic  w_hit;
   psum_t prod;

   // Loads are broadcast to the row, each tile decodes its own index
   assign act_hit = act_load.valid && (act_load.tile == tile_idx_t'(TILE_IDX));
   assign w_hit   = w_load.valid && (w_load.tile == tile_idx_t'(TILE_IDX));

   always_ff @(posedge clk_h) begin
      if (act_hit) begin
         act_mem[act_load.addr] <= act_load.data;
      end
      if (w_hit) begin
         w_mem[w_load.addr] <= w_load.data;
      end
      // One-cycle read so operands meet sum_in in the next cycle
      if (step.valid) begin
         act_q <= act_mem[step.act_addr];
         w_q   <= w_mem[step.w_addr];
      end
   end

   // Signed operands extend to 32 bits before the multiply
   assign prod = act_q * w_q;

   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         rd_vld_q <= 1'b0;
         sum_out  <= '0;
      end else begin
         rd_vld_q <= step.valid;
         // Chain sum only moves on a real step
         if (rd_vld_q) begin
            sum_out <= sum_in + prod;
         end
      end
   end

endmodule

// File: source/sblk_unit.sv
// Top level with controller, address and write-back skew lines, tile row and partial-sum buffer
`timescale 1ns/100ps

module sblk_unit #(
   parameter int N_TILE = sblk_cfg_pkg::N_TILE_DEF
) (
   input  logic                     clk_h,
   input  logic                     rst_n,
   // Operand loads, no back-pressure
   input  sblk_cmd_pkg::act_load_t  act_load,
   input  sblk_cmd_pkg::w_load_t    w_load,
   // Command handshake
   input  sblk_cmd_pkg::sblk_cmd_t  cmd,
   input  logic                     cmd_valid,
   output logic                     cmd_ready,
   output logic                     done,
   // Host readback, two-cycle latency
   input  logic                     host_rd_en,
   input  sblk_cfg_pkg::psum_addr_t host_rd_addr,
   output sblk_cfg_pkg::psum_t      host_rd_data,
   output logic                     host_rd_valid
);

   import sblk_cfg_pkg::*;
   import sblk_cmd_pkg::*;

   // Issue-cycle records from the controller
   step_addr_t step;
   psum_wb_t   wb;
   logic       psum_rd_en;
   psum_addr_t psum_rd_addr;

   // Tile t reads tap t+1, the buffer writes from the last write-back tap
   step_addr_t addr_taps [N_TILE+1];
   psum_wb_t   wb_taps   [N_TILE+3];

   // Entry 0 is the accumulate read data, entry t+1 is tile t's sum
   psum_t      sum_chain [N_TILE+1];

   sblk_ctrl #(
      .N_TILE (N_TILE)
   ) u_ctrl (
      .clk_h        (clk_h),
      .rst_n        (rst_n),
      .cmd          (cmd),
      .cmd_valid    (cmd_valid),
      .cmd_ready    (cmd_ready),
      .step         (step),
      .wb           (wb),
      .psum_rd_en   (psum_rd_en),
      .psum_rd_addr (psum_rd_addr),
      .wb_tap       (wb_taps[N_TILE+2]),
      .done         (done)
   );

   // One cycle of skew per tile
   skew_line #(
      .T     (step_addr_t),
      .DEPTH (N_TILE)
   ) addr_skew (
      .clk_h (clk_h),
      .rst_n (rst_n),
      .din   (step),
      .taps  (addr_taps)
   );

   // Covers the skew, the buffer read and the tile sum register
   skew_line #(
      .T     (psum_wb_t),
      .DEPTH (N_TILE+2)
   ) wb_skew (
      .clk_h (clk_h),
      .rst_n (rst_n),
      .din   (wb),
      .taps  (wb_taps)
   );

   generate
      for (genvar i = 0; i < N_TILE; i++) begin : g_tile
         sblk_tile #(
            .TILE_IDX (i)
         ) u_tile (
            .clk_h    (clk_h),
            .rst_n    (rst_n),
            .act_load (act_load),
            .w_load   (w_load),
            .step     (addr_taps[i+1]),
            .sum_in   (sum_chain[i]),
            .sum_out  (sum_chain[i+1])
         );
      end
   endgenerate

   psum_buf u_psum_buf (
      .clk_h         (clk_h),
      .rst_n         (rst_n),
      .rd_en         (psum_rd_en),
      .rd_addr       (psum_rd_addr),
      .acc_data      (sum_chain[0]),
      .host_rd_en    (host_rd_en),
      .host_rd_addr  (host_rd_addr),
      .host_rd_data  (host_rd_data),
      .host_rd_valid (host_rd_valid),
      .wb            (wb_taps[N_TILE+2]),
      .wr_data       (sum_chain[N_TILE])
   );

endmodule

// File: source/skew_line.sv
// Type-parameterized shift register with every stage exposed as a tap
`timescale 1ns/100ps

module skew_line #(
   parameter type T     = logic,
   parameter int  DEPTH = 1
) (
   input  logic clk_h,
   input  logic rst_n,
   input  T     din,
   output T     taps [DEPTH+1]
);

   // Stage i holds din delayed by i+1 cycles
   T stage_q [DEPTH];

   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < DEPTH; i++) begin
            stage_q[i] <= '0;
         end
      end else begin
         stage_q[0] <= din;
         for (int i = 1; i < DEPTH; i++) begin
            stage_q[i] <= stage_q[i-1];
         end
      end
   end

   // Tap 0 is the undelayed input
   always_comb begin
      taps[0] = din;
      for (int i = 0; i < DEPTH; i++) begin
         taps[i+1] = stage_q[i];
      end
   end

endmodule

// File: tb/sblk_unit_assert.sv
// Concurrent checks on the command handshake, done pulse and write-back activity
`timescale 1ns/100ps

module sblk_unit_assert (
   input logic                   clk_h,
   input logic                   rst_n,
   input logic                   cmd_valid,
   input logic                   cmd_ready,
   input logic                   done,
   input sblk_cmd_pkg::psum_wb_t wb
);

   // Ready drops right after an accepted command
   a_busy_after_accept: assert property (
      @(posedge clk_h) disable iff (!rst_n)
      (cmd_valid && cmd_ready) |=> !cmd_ready
   ) else $error("cmd_ready still high the cycle after a command was accepted");

   // Ready only reopens together with done
   a_ready_with_done: assert property (
      @(posedge clk_h) disable iff (!rst_n)
      $rose(cmd_ready) |-> done
   ) else $error("cmd_ready rose without a done pulse");

   // Single-cycle done
   a_done_pulse: assert property (
      @(posedge clk_h) disable iff (!rst_n)
      done |=> !done
   ) else $error("done held high for two cycles");

   // Write-back records only come out of a running command
   a_no_wb_idle: assert property (
      @(posedge clk_h) disable iff (!rst_n)
      wb.valid |-> !cmd_ready
   ) else $error("write-back valid while the controller is idle");

endmodule

bind sblk_ctrl sblk_unit_assert u_ctrl_assert (
   .clk_h     (clk_h),
   .rst_n     (rst_n),
   .cmd_valid (cmd_valid),
   .cmd_ready (cmd_ready),
   .done      (done),
   .wb        (wb)
);

// File: tb/sblk_unit_stimulus.txt
# A/W tile addr value = activation/weight load, R addr expected = readback, all hex
# C act_base w_base psum_base len acc gap, gap 0 keeps cmd_valid high from the last command
A 0 1f 0064
A 1 1f fff9
A 2 1f 0003
A 3 1f 7fff
W 0 1f fffd
W 1 1f 0004
W 2 1f 000b
W 3 1f 7fff
A 0 00 0003
A 1 00 0004
A 2 00 ffff
A 3 00 000a
W 0 00 0002
W 1 00 fffb
W 2 00 0006
W 3 00 0001
C 1f 1f 00 2 0 2
R 00 3ffefeda
R 01 fffffff6
C 1f 1f 00 2 1 1
R 00 7ffdfdb4
R 01 ffffffec
C 1f 1f 10 2 0 3
C 00 1f 20 1 0 0
R 11 fffffff6
R 20 0004fff2
C 1f 1f 3f 2 0 2
C 1f 1f 3f 2 1 1
R 3f 7ffdfdb4
R 00 ffffffec

// File: tb/tb_sblk_unit.sv
// Super block testbench with clock, reset, file-driven stimulus, monitors and compare tasks
`timescale 1ns/100ps

module tb_sblk_unit;

   import sblk_cfg_pkg::*;
   import sblk_cmd_pkg::*;

   localparam int N_TILE   = N_TILE_DEF;
   localparam int WAIT_MAX = 200;

   logic       clk_h;
   logic       rst_n;
   act_load_t  act_load;
   w_load_t    w_load;
   sblk_cmd_t  cmd;
   logic       cmd_valid;
   logic       cmd_ready;
   logic       done;
   logic       host_rd_en;
   psum_addr_t host_rd_addr;
   psum_t      host_rd_data;
   logic       host_rd_valid;

   // Cycle count, expected done cycles and host read enable history
   int         cyc = 0;
   int         done_due [$];
   logic [1:0] rd_en_hist = '0;
   integer     seed;

   sblk_unit #(
      .N_TILE (N_TILE)
   ) dut0 (
      .clk_h         (clk_h),
      .rst_n         (rst_n),
      .act_load      (act_load),
      .w_load        (w_load),
      .cmd           (cmd),
      .cmd_valid     (cmd_valid),
      .cmd_ready     (cmd_ready),
      .done          (done),
      .host_rd_en    (host_rd_en),
      .host_rd_addr  (host_rd_addr),
      .host_rd_data  (host_rd_data),
      .host_rd_valid (host_rd_valid)
   );

   always #5 clk_h = ~clk_h;

   always @(posedge clk_h) begin
      cyc <= cyc + 1;
   end

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Some tests failed");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic check_psum(input string name, input psum_t exp, input psum_t got);
      if (got !== exp) begin
         fail_run($sformatf("ERROR %s: expected %08h actual %08h", name, exp, got));
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic got);
      if (got !== exp) begin
         fail_run($sformatf("ERROR %s: expected %0b actual %0b", name, exp, got));
      end
   endtask

   // Mid-cycle monitor of done timing, acceptance only when idle and read latency
   always @(negedge clk_h) begin
      if (rst_n) begin
         check_bit("done timing", (done_due.size() > 0) && (done_due[0] == cyc), done);
         if (done) begin
            void'(done_due.pop_front());
         end
         if (cmd_valid && cmd_ready) begin
            check_bit("accept only after done", 1'b0, done_due.size() > 0);
            done_due.push_back(cyc + int'(cmd.len) + N_TILE + 3);
         end
         check_bit("host read latency", rd_en_hist[1], host_rd_valid);
         rd_en_hist <= {rd_en_hist[0], host_rd_en};
      end
   end

   // Idle values that a later assignment in the same cycle overrides
   task automatic drive_idle();
      cmd_valid  <= 1'b0;
      act_load   <= '0;
      w_load     <= '0;
      host_rd_en <= 1'b0;
   endtask

   task automatic wait_idle();
      int n;
      n = 0;
      do begin
         @(negedge clk_h);
         n++;
         if (n > WAIT_MAX) fail_run("Timeout: the unit did not return to idle");
      end while (!(cmd_ready && !done));
   endtask

   task automatic load_word(input logic is_w, input tile_idx_t t, input act_addr_t a,
                            input logic [15:0] v);
      @(posedge clk_h);
      drive_idle();
      if (is_w) w_load <= '{valid: 1'b1, tile: t, addr: a, data: v};
      else act_load <= '{valid: 1'b1, tile: t, addr: a, data: v};
   endtask

   // Gap 0 offers the command right behind the previous one
   task automatic send_cmd(input sblk_cmd_t c, input int gap);
      int idle;
      int n;
      idle = (gap == 0) ? 0 : gap + ($random(seed) & 3);
      repeat (idle) begin
         @(posedge clk_h);
         drive_idle();
      end
      @(posedge clk_h);
      drive_idle();
      cmd       <= c;
      cmd_valid <= 1'b1;
      n = 0;
      do begin
         @(negedge clk_h);
         n++;
         if (n > WAIT_MAX) fail_run("Timeout: a command was never accepted");
      end while (!cmd_ready);
   endtask

   task automatic read_back(input psum_addr_t addr, input psum_t exp, input string name);
      int n;
      @(posedge clk_h);
      drive_idle();
      wait_idle();
      @(posedge clk_h);
      drive_idle();
      host_rd_en   <= 1'b1;
      host_rd_addr <= addr;
      @(posedge clk_h);
      drive_idle();
      n = 0;
      do begin
         @(negedge clk_h);
         n++;
         if (n > WAIT_MAX) fail_run("Timeout: host_rd_valid never came back");
      end while (!host_rd_valid);
      check_psum(name, exp, host_rd_data);
   endtask

   initial begin
      int          fd;
      int          code;
      int          ch;
      int          line;
      logic [7:0]  kind;
      logic [31:0] f0, f1, f2, f3, f4, f5;
      sblk_cmd_t   c;

      seed  = 32'h56fe;
      clk_h = 1'b0;
      rst_n        <= 1'b0;
      act_load     <= '0;
      w_load       <= '0;
      cmd          <= '0;
      cmd_valid    <= 1'b0;
      host_rd_en   <= 1'b0;
      host_rd_addr <= '0;
      repeat (3) @(posedge clk_h);
      rst_n <= 1'b1;

      // Idle state out of reset
      @(negedge clk_h);
      check_bit("reset cmd_ready", 1'b1, cmd_ready);
      check_bit("reset done", 1'b0, done);
      check_bit("reset host_rd_valid", 1'b0, host_rd_valid);

      fd = $fopen("tb/sblk_unit_stimulus.txt", "r");
      if (fd == 0) fail_run("Cannot open tb/sblk_unit_stimulus.txt");
      line = 1;
      code = $fscanf(fd, " %c", kind);
      while (code == 1) begin
         case (kind)
            "#": begin
               ch = $fgetc(fd);
               while (ch != 10 && ch != -1) ch = $fgetc(fd);
            end
            "A", "W": begin
               code = $fscanf(fd, "%h %h %h", f0, f1, f2);
               if (code != 3) fail_run($sformatf("Bad load record on line %0d", line));
               load_word(kind == "W", tile_idx_t'(f0), act_addr_t'(f1), f2[15:0]);
            end
            "C": begin
               code = $fscanf(fd, "%h %h %h %h %h %h", f0, f1, f2, f3, f4, f5);
               if (code != 6) fail_run($sformatf("Bad command record on line %0d", line));
               c.act_base  = act_addr_t'(f0);
               c.w_base    = w_addr_t'(f1);
               c.psum_base = psum_addr_t'(f2);
               c.len       = len_t'(f3);
               c.acc       = f4[0];
               send_cmd(c, int'(f5));
            end
            "R": begin
               code = $fscanf(fd, "%h %h", f0, f1);
               if (code != 2) fail_run($sformatf("Bad readback record on line %0d", line));
               read_back(psum_addr_t'(f0), psum_t'(f1),
                         $sformatf("readback addr %02h line %0d", f0[5:0], line));
            end
            default: fail_run($sformatf("Unknown record kind on line %0d", line));
         endcase
         line++;
         code = $fscanf(fd, " %c", kind);
      end
      $fclose(fd);

      @(posedge clk_h);
      drive_idle();
      wait_idle();
      if (done_due.size() != 0) begin
         fail_run("An accepted command never produced its done pulse");
      end else begin
         $display("All tests passed");
         $finish;
      end
   end

endmodule
